//--- ftdi_bridge.f
+incdir+common
common/ftdi_bridge_pkg.sv
hw/uart/uart_rx.sv
hw/uart/uart_tx.sv
hw/packet_router.sv
hw/status_leds.sv
hw/debug_regs.sv
hw/ftdi_bridge_top.sv
bench/ftdi_bridge_asserts.sv
bench/ftdi_bridge_tb.sv

//--- Bender.yml
package:
  name: ftdi_bridge

sources:
  - include_dirs:
      - common
    files:
      - common/ftdi_bridge_pkg.sv
      - hw/uart/uart_rx.sv
      - hw/uart/uart_tx.sv
      - hw/packet_router.sv
      - hw/status_leds.sv
      - hw/debug_regs.sv
      - hw/ftdi_bridge_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/ftdi_bridge_asserts.sv
      - bench/ftdi_bridge_tb.sv

//--- bench/ftdi_bridge_tb.sv
// Testbench for the FTDI to SpiNNaker bridge
// Drives the host UART, the multiplexer channels, the status inputs and APB.
// Checks packets both ways, the drop path, the debug registers and both LEDs.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module ftdi_bridge_tb
	import ftdi_bridge_pkg::*;
();
	localparam int FRAME_BITS   = `PKT_BYTES * 10;             // 8N1 bits per packet
	localparam int FRAME_CYCLES = FRAME_BITS * `BAUD_PERIOD;
	localparam int N_RX         = 3;                           // UART to channel 0
	localparam int N_TX         = 3;                           // Channel 0 to UART
	localparam int STEADY       = 1 << (`BLINK_BIT + 2);       // Two blink periods
	localparam int BLINK_WIN    = (1 << (`BLINK_BIT + 1)) + 2;
	localparam int LED_CYCLES   = 2 * (`ACTIVITY_TIMEOUT + 8 + STEADY + BLINK_WIN);
	localparam int TIMEOUT      = 2 * ((N_RX + N_TX + 2) * FRAME_CYCLES + LED_CYCLES);

	logic       clk_i = 1'b0;
	logic       rst_i;
	logic       uart_rx_i;
	logic       uart_tx_o;
	logic       uart_cts_o;
	pkt_t       hss_tx_data_o [`NUM_CHANS];
	logic       hss_tx_vld_o  [`NUM_CHANS];
	logic       hss_tx_rdy_i  [`NUM_CHANS];
	pkt_t       hss_rx_data_i [`NUM_CHANS];
	logic       hss_rx_vld_i  [`NUM_CHANS];
	logic       hss_rx_rdy_o  [`NUM_CHANS];
	logic       handshake_complete_i;
	logic       version_mismatch_i;
	logic [1:0] leds_o;
	logic       apb_psel_i;
	logic       apb_penable_i;
	logic       apb_pwrite_i;
	apb_addr_t  apb_paddr_i;
	apb_data_t  apb_pwdata_i;
	apb_data_t  apb_prdata_o;
	logic       apb_pready_o;
	logic       apb_pslverr_o;

	logic [31:0] lcg_state = 32'h82c73661;
	int unsigned cycle_cnt = 0;
	int unsigned hss_seen  = 0;    // Packets checked on channel 0
	int unsigned uart_seen = 0;    // Packets decoded off uart_tx_o
	int unsigned n_uart2hss = 0;
	int unsigned n_hss2uart = 0;
	int unsigned n_dropped  = 0;
	pkt_t        exp_hss  [$];
	pkt_t        exp_uart [$];

	ftdi_bridge_top ftdi_bridge_top_i (.*);

	always #20 clk_i = ~clk_i;  // 40 ns period

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic pkt_t rand_pkt();
		logic [95:0] r;
		for (int i = 0; i < 3; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			r = {r[63:0], lcg_state};
		end
		return r[`PKT_BITS-1:0];
	endfunction

	// Packet to line bits with bit 0 sent first
	function automatic logic [FRAME_BITS-1:0] serialise(input pkt_t p);
		logic [FRAME_BITS-1:0] f;
		for (int b = 0; b < `PKT_BYTES; b++)
			f[b*10 +: 10] = {1'b1, p[b*8 +: 8], 1'b0};  // Stop, data, start
		return f;
	endfunction

	function automatic pkt_t assemble(input logic [FRAME_BITS-1:0] f, output logic framed);
		pkt_t p;
		framed = 1'b1;
		for (int b = 0; b < `PKT_BYTES; b++)
		begin
			p[b*8 +: 8] = f[b*10+1 +: 8];
			if (f[b*10] !== 1'b0 || f[b*10+9] !== 1'b1)
				framed = 1'b0;   // Bad start or stop
		end
		return p;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [`PKT_BITS-1:0] got,
			input logic [`PKT_BITS-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR %s: got %0h, expected %0h", name, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	task automatic send_uart_packet(input pkt_t p);
		logic [FRAME_BITS-1:0] f;
		f = serialise(p);
		for (int b = 0; b < FRAME_BITS; b++)
		begin
			uart_rx_i <= f[b];
			repeat (`BAUD_PERIOD) @(posedge clk_i);
		end
	endtask

	task automatic send_hss_packet(input pkt_t p);
		hss_rx_data_i[0] <= p;
		hss_rx_vld_i[0]  <= 1'b1;
		do
			@(posedge clk_i);
		while (!hss_rx_rdy_o[0]);  // Held off while uart_tx is busy
		hss_rx_vld_i[0] <= 1'b0;
	endtask

	// Setup phase then access phase where the result is sampled
	task automatic check_reg(input apb_addr_t addr, input logic write, input apb_data_t exp_data,
			input logic exp_err);
		apb_psel_i    <= 1'b1;
		apb_penable_i <= 1'b0;
		apb_pwrite_i  <= write;
		apb_paddr_i   <= addr;
		apb_pwdata_i  <= 32'h5a5a_5a5a;
		@(posedge clk_i);
		apb_penable_i <= 1'b1;
		do
			@(posedge clk_i);
		while (!apb_pready_o);
		check_value($sformatf("apb_prdata_o at %0h", addr), apb_prdata_o, exp_data);
		check_value("apb_pslverr_o", apb_pslverr_o, exp_err);
		apb_psel_i    <= 1'b0;
		apb_penable_i <= 1'b0;
	endtask

	task automatic expect_leds_steady(input logic [1:0] level, input int cycles);
		repeat (cycles)
		begin
			@(posedge clk_i);
			check_value("leds_o", leds_o, level);
		end
	endtask

	// Both levels must show up on one LED within a blink window
	task automatic expect_led_blink(input int idx);
		logic [1:0] seen;
		seen = 2'b00;
		repeat (BLINK_WIN)
		begin
			@(posedge clk_i);
			seen[leds_o[idx]] = 1'b1;
		end
		if (seen != 2'b11)
			abort_run($sformatf("leds_o[%0d] did not blink while an error was recent", idx));
	endtask

	////////////////////////////////////////////////////////////
	// Monitors and timeout
	////////////////////////////////////////////////////////////

	always @(posedge clk_i)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT)
			abort_run("Timeout, the tests did not finish in time");
	end

	// Channel 0 transmit compare and idle channel watch
	always @(posedge clk_i)
	begin
		if (rst_i === 1'b0)
		begin
			for (int i = 1; i < `NUM_CHANS; i++)
				if (hss_tx_vld_o[i] !== 1'b0 || hss_rx_rdy_o[i] !== 1'b1)
					abort_run($sformatf("Idle channel %0d did not stay idle", i));
			if (hss_tx_vld_o[0] && hss_tx_rdy_i[0])
			begin
				if (exp_hss.size() == 0)
					abort_run("A packet appeared on hss_tx channel 0 that was not sent");
				else
				begin
					check_value("hss_tx_data_o[0]", hss_tx_data_o[0], exp_hss.pop_front());
					hss_seen++;
				end
			end
		end
	end

	// UART decode where every bit must hold for a full baud period
	initial
	begin
		logic [FRAME_BITS-1:0] bits;
		logic                  framed;
		pkt_t                  got;
		forever
		begin
			@(posedge clk_i);
			if (rst_i === 1'b0 && uart_tx_o === 1'b0)
			begin
				for (int b = 0; b < FRAME_BITS; b++)
					for (int s = 0; s < `BAUD_PERIOD; s++)
					begin
						if (b != 0 || s != 0)
							@(posedge clk_i);
						if (s == 0)
							bits[b] = uart_tx_o;
						else if (uart_tx_o !== bits[b])
							abort_run($sformatf("UART bit %0d was not a full baud period", b));
					end
				got = assemble(bits, framed);
				if (!framed)
					abort_run("Framing error on uart_tx_o");
				else if (exp_uart.size() == 0)
					abort_run("A packet appeared on uart_tx_o that was not sent");
				else
				begin
					check_value("uart_tx_o packet", got, exp_uart.pop_front());
					uart_seen++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		pkt_t       p;
		logic       framed;
		rst_i                = 1'b1;
		uart_rx_i            = 1'b1;    // Line idle
		handshake_complete_i = 1'b1;
		version_mismatch_i   = 1'b0;
		apb_psel_i           = 1'b0;
		apb_penable_i        = 1'b0;
		apb_pwrite_i         = 1'b0;
		apb_paddr_i          = '0;
		apb_pwdata_i         = '0;
		for (int i = 0; i < `NUM_CHANS; i++)
		begin
			hss_tx_rdy_i[i]  = 1'b1;
			hss_rx_data_i[i] = '0;
			hss_rx_vld_i[i]  = 1'b0;
		end
		repeat (5) @(posedge clk_i);
		rst_i <= 1'b0;
		@(posedge clk_i);
		check_value("uart_tx_o", uart_tx_o, 1'b1);
		check_value("uart_cts_o", uart_cts_o, 1'b1);
		check_value("leds_o", leds_o, 2'b00);

		// UART packets onto channel 0
		for (int n = 0; n < N_RX; n++)
		begin
			p = rand_pkt();
			exp_hss.push_back(assemble(serialise(p), framed));
			send_uart_packet(p);
			n_uart2hss++;
		end
		while (hss_seen < N_RX)
			@(posedge clk_i);

		// Traffic on channels 1 to 7 is drained, then channel 0 goes out on the UART
		repeat (4)
		begin
			for (int c = 1; c < `NUM_CHANS; c++)
			begin
				hss_rx_data_i[c] <= rand_pkt();
				hss_rx_vld_i[c]  <= 1'b1;
			end
			@(posedge clk_i);
		end
		for (int c = 1; c < `NUM_CHANS; c++)
			hss_rx_vld_i[c] <= 1'b0;
		for (int n = 0; n < N_TX; n++)
		begin
			p = rand_pkt();
			exp_uart.push_back(p);
			send_hss_packet(p);
			n_hss2uart++;
		end
		while (uart_seen < N_TX)
			@(posedge clk_i);

		// Back-pressure drops the second packet
		hss_tx_rdy_i[0] <= 1'b0;
		p = rand_pkt();
		send_uart_packet(p);
		repeat (2) @(posedge clk_i);
		check_value("uart_cts_o", uart_cts_o, 1'b0);
		send_uart_packet(rand_pkt());
		n_dropped++;
		exp_hss.push_back(p);
		n_uart2hss++;
		hss_tx_rdy_i[0] <= 1'b1;
		while (hss_seen < N_RX + 1)
			@(posedge clk_i);
		repeat (`BAUD_PERIOD) @(posedge clk_i);
		check_value("uart_cts_o", uart_cts_o, 1'b1);
		expect_led_blink(1);   // The drop is a recent UART error

		// Debug registers
		check_reg(`REG_VERSION, 1'b0, `BRIDGE_VERSION, 1'b0);
		check_reg(`REG_STATUS, 1'b0, {30'b0, version_mismatch_i, handshake_complete_i}, 1'b0);
		check_reg(`REG_UART2HSS, 1'b0, n_uart2hss, 1'b0);
		check_reg(`REG_HSS2UART, 1'b0, n_hss2uart, 1'b0);
		check_reg(`REG_DROPPED, 1'b0, n_dropped, 1'b0);
		check_reg(`REG_VERSION, 1'b1, '0, 1'b1);   // Bank is read only
		check_reg(8'h14, 1'b0, '0, 1'b1);

		// LEDs while quiet and connected, then with mismatch and with the HSS link down
		repeat (`ACTIVITY_TIMEOUT + 8) @(posedge clk_i);
		expect_leds_steady(2'b11, STEADY);
		version_mismatch_i <= 1'b1;
		expect_led_blink(0);
		version_mismatch_i   <= 1'b0;
		handshake_complete_i <= 1'b0;
		repeat (`ACTIVITY_TIMEOUT + 8) @(posedge clk_i);   // Let the error age out
		expect_leds_steady(2'b10, STEADY);

		if (ftdi_bridge_top_i.ftdi_bridge_asserts_i.fail_cnt != 0)
			abort_run("Assertions on the packet ports failed");
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

//--- bench/ftdi_bridge_asserts.sv
// Concurrent checks on the bridge packet ports
// Bound into the top level at the bottom of this file. Covers the idle
// channel tie-offs and the channel 0 transmit handshake.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module ftdi_bridge_asserts
	import ftdi_bridge_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	input pkt_t hss_tx_data_o [`NUM_CHANS],
	input logic hss_tx_vld_o  [`NUM_CHANS],
	input logic hss_tx_rdy_i  [`NUM_CHANS],
	input logic hss_rx_rdy_o  [`NUM_CHANS]
);
	int unsigned fail_cnt = 0;   // Failed assertions so far

	for (genvar i = 1; i < `NUM_CHANS; i++)
	begin : g_idle_chan
		idle_tx_a: assert property (@(posedge clk_i) disable iff (rst_i) !hss_tx_vld_o[i])
		else
		begin
			fail_cnt++;
			$error("hss_tx_vld_o[%0d] rose on an idle channel", i);
		end
		drain_rx_a: assert property (@(posedge clk_i) disable iff (rst_i) hss_rx_rdy_o[i])
		else
		begin
			fail_cnt++;
			$error("hss_rx_rdy_o[%0d] dropped on an idle channel", i);
		end
	end

	// Valid and data held until ready
	tx_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
		hss_tx_vld_o[0] && !hss_tx_rdy_i[0] |=> hss_tx_vld_o[0] && $stable(hss_tx_data_o[0]))
	else
	begin
		fail_cnt++;
		$error("hss_tx channel 0 changed before ready");
	end

endmodule

bind ftdi_bridge_top ftdi_bridge_asserts ftdi_bridge_asserts_i (
	.clk_i         (clk_i),
	.rst_i         (rst_i),
	.hss_tx_data_o (hss_tx_data_o),
	.hss_tx_vld_o  (hss_tx_vld_o),
	.hss_tx_rdy_i  (hss_tx_rdy_i),
	.hss_rx_rdy_o  (hss_rx_rdy_o)
);

//--- hw/ftdi_bridge_top.sv
// Top level of the FTDI to SpiNNaker bridge
// Connects the host UART to multiplexer channel 0, drives the HSS and UART
// status LEDs and exposes the debug registers on APB.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module ftdi_bridge_top
	import ftdi_bridge_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	// Host UART
	input  logic       uart_rx_i,
	output logic       uart_tx_o,
	output logic       uart_cts_o,
	// Multiplexer packet channels
	output pkt_t       hss_tx_data_o [`NUM_CHANS],
	output logic       hss_tx_vld_o  [`NUM_CHANS],
	input  logic       hss_tx_rdy_i  [`NUM_CHANS],
	input  pkt_t       hss_rx_data_i [`NUM_CHANS],
	input  logic       hss_rx_vld_i  [`NUM_CHANS],
	output logic       hss_rx_rdy_o  [`NUM_CHANS],
	// Multiplexer status
	input  logic       handshake_complete_i,
	input  logic       version_mismatch_i,
	output logic [1:0] leds_o,         // [1] UART, [0] HSS
	// Debug bus
	input  logic       apb_psel_i,
	input  logic       apb_penable_i,
	input  logic       apb_pwrite_i,
	input  apb_addr_t  apb_paddr_i,
	input  apb_data_t  apb_pwdata_i,
	output apb_data_t  apb_prdata_o,
	output logic       apb_pready_o,
	output logic       apb_pslverr_o
);
	pkt_t rx_pkt;         // UART toward SpiNNaker
	logic rx_pkt_vld;
	logic rx_pkt_rdy;
	pkt_t tx_pkt;         // SpiNNaker toward UART
	logic tx_pkt_vld;
	logic tx_pkt_rdy;
	logic line_ok;
	cnt_t dropped_cnt;
	cnt_t dropped_prev;
	logic drop_evt;
	logic hss_activity;
	logic uart_activity;
	cnt_t uart2hss_cnt;
	cnt_t hss2uart_cnt;

	////////////////////////////////////////////////////////////
	// Host UART
	////////////////////////////////////////////////////////////

	uart_rx uart_rx_core_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rx_i       (uart_rx_i),
		.pkt_data_o (rx_pkt),
		.pkt_vld_o  (rx_pkt_vld),
		.pkt_rdy_i  (rx_pkt_rdy),
		.cts_o      (uart_cts_o),
		.line_ok_o  (line_ok),
		.dropped_o  (dropped_cnt)
	);

	uart_tx uart_tx_core_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pkt_data_i (tx_pkt),
		.pkt_vld_i  (tx_pkt_vld),
		.pkt_rdy_o  (tx_pkt_rdy),
		.tx_o       (uart_tx_o)
	);

	////////////////////////////////////////////////////////////
	// Channel routing
	////////////////////////////////////////////////////////////

	packet_router packet_router_i (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.uart_pkt_i      (rx_pkt),
		.uart_vld_i      (rx_pkt_vld),
		.uart_rdy_o      (rx_pkt_rdy),
		.hss_tx_data_o   (hss_tx_data_o),
		.hss_tx_vld_o    (hss_tx_vld_o),
		.hss_tx_rdy_i    (hss_tx_rdy_i),
		.hss_rx_data_i   (hss_rx_data_i),
		.hss_rx_vld_i    (hss_rx_vld_i),
		.hss_rx_rdy_o    (hss_rx_rdy_o),
		.out_pkt_o       (tx_pkt),
		.out_vld_o       (tx_pkt_vld),
		.out_rdy_i       (tx_pkt_rdy),
		.hss_activity_o  (hss_activity),
		.uart_activity_o (uart_activity),
		.uart2hss_cnt_o  (uart2hss_cnt),
		.hss2uart_cnt_o  (hss2uart_cnt)
	);

	////////////////////////////////////////////////////////////
	// Status LEDs
	////////////////////////////////////////////////////////////

	// One-cycle pulse whenever the drop counter moves
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			dropped_prev <= '0;
		else
			dropped_prev <= dropped_cnt;
	end

	assign drop_evt = (dropped_cnt != dropped_prev);

	status_leds hss_led_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.error_i     (version_mismatch_i),
		.connected_i (handshake_complete_i),
		.activity_i  (hss_activity),
		.led_o       (leds_o[0])
	);

	status_leds uart_led_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.error_i     (drop_evt),
		.connected_i (line_ok),
		.activity_i  (uart_activity),
		.led_o       (leds_o[1])
	);

	// Debug register bank
	debug_regs debug_regs_i (
		.clk_i                (clk_i),
		.rst_i                (rst_i),
		.apb_psel_i           (apb_psel_i),
		.apb_penable_i        (apb_penable_i),
		.apb_pwrite_i         (apb_pwrite_i),
		.apb_paddr_i          (apb_paddr_i),
		.apb_pwdata_i         (apb_pwdata_i),
		.apb_prdata_o         (apb_prdata_o),
		.apb_pready_o         (apb_pready_o),
		.apb_pslverr_o        (apb_pslverr_o),
		.handshake_complete_i (handshake_complete_i),
		.version_mismatch_i   (version_mismatch_i),
		.uart2hss_cnt_i       (uart2hss_cnt),
		.hss2uart_cnt_i       (hss2uart_cnt),
		.dropped_i            (dropped_cnt)
	);

endmodule

//--- hw/debug_regs.sv
// Read-only debug register bank on APB
// Holds the bridge version, the link status and the packet counters.
// Writes and unknown offsets answer with a slave error.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module debug_regs
	import ftdi_bridge_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      apb_psel_i,
	input  logic      apb_penable_i,
	input  logic      apb_pwrite_i,
	input  apb_addr_t apb_paddr_i,
	input  apb_data_t apb_pwdata_i,   // Ignored, bank is read only
	output apb_data_t apb_prdata_o,
	output logic      apb_pready_o,
	output logic      apb_pslverr_o,
	input  logic      handshake_complete_i,
	input  logic      version_mismatch_i,
	input  cnt_t      uart2hss_cnt_i,
	input  cnt_t      hss2uart_cnt_i,
	input  cnt_t      dropped_i
);
	logic [1:0] status_q;   // [1] mismatch, [0] handshake done
	apb_data_t  rdata;
	logic       addr_ok;
	logic       access;

	// Link status register
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			status_q <= '0;
		else
			status_q <= {version_mismatch_i, handshake_complete_i};
	end

	// Address decode
	always_comb
	begin
		rdata   = '0;
		addr_ok = 1'b1;
		case (apb_paddr_i)
			`REG_VERSION:  rdata = `BRIDGE_VERSION;
			`REG_STATUS:   rdata = apb_data_t'(status_q);
			`REG_UART2HSS: rdata = apb_data_t'(uart2hss_cnt_i);
			`REG_HSS2UART: rdata = apb_data_t'(hss2uart_cnt_i);
			`REG_DROPPED:  rdata = apb_data_t'(dropped_i);
			default:       addr_ok = 1'b0;
		endcase
	end

	assign access        = apb_psel_i && apb_penable_i;  // Access phase
	assign apb_pready_o  = 1'b1;                         // No wait states
	assign apb_pslverr_o = access && (apb_pwrite_i || !addr_ok);
	assign apb_prdata_o  = (access && !apb_pwrite_i && addr_ok) ? rdata : '0;

endmodule

//--- hw/status_leds.sv
// Status LED driver for one link
// Blinks on error, shows steady on when connected with a flicker on recent
// traffic, off otherwise. One instance per LED.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module status_leds
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic error_i,
	input  logic connected_i,
	input  logic activity_i,
	output logic led_o
);
	localparam int TMR_W = $clog2(`ACTIVITY_TIMEOUT + 1);
	localparam logic [TMR_W-1:0] TMR_LOAD = TMR_W'(`ACTIVITY_TIMEOUT);

	logic [`BLINK_BIT:0] period_cnt;
	logic [1:0]          evt;             // [1] error, [0] activity
	logic [TMR_W-1:0]    recent_tmr [2];
	logic                blink;
	logic                act_recent;
	logic                err_recent;
	logic                led_next;

	assign evt        = {error_i, activity_i};
	assign blink      = period_cnt[`BLINK_BIT];
	assign act_recent = (recent_tmr[0] != '0);
	assign err_recent = (recent_tmr[1] != '0);

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			period_cnt <= '0;
		else
			period_cnt <= period_cnt + 1'b1;  // Free running
	end

	// Retriggerable timers, one per event kind
	always_ff @(posedge clk_i)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (rst_i)
				recent_tmr[i] <= '0;
			else if (evt[i])
				recent_tmr[i] <= TMR_LOAD;
			else if (recent_tmr[i] != '0)
				recent_tmr[i] <= recent_tmr[i] - 1'b1;
		end
	end

	always_comb
	begin
		if (error_i || err_recent)
			led_next = blink;
		else if (connected_i)
			led_next = !(act_recent && blink);  // Off phase of the flicker
		else
			led_next = 1'b0;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			led_o <= 1'b0;
		else
			led_o <= led_next;
	end

endmodule

//--- hw/packet_router.sv
// Packet routing between the UART and the multiplexer channels
// Channel 0 carries the UART traffic both ways, the other channels are idle on
// transmit and drain on receive. Also makes activity pulses and counters.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module packet_router
	import ftdi_bridge_pkg::*;
(
	input  logic clk_i,
	input  logic rst_i,
	input  pkt_t uart_pkt_i,
	input  logic uart_vld_i,
	output logic uart_rdy_o,
	output pkt_t hss_tx_data_o [`NUM_CHANS],
	output logic hss_tx_vld_o  [`NUM_CHANS],
	input  logic hss_tx_rdy_i  [`NUM_CHANS],
	input  pkt_t hss_rx_data_i [`NUM_CHANS],
	input  logic hss_rx_vld_i  [`NUM_CHANS],
	output logic hss_rx_rdy_o  [`NUM_CHANS],
	output pkt_t out_pkt_o,
	output logic out_vld_o,
	input  logic out_rdy_i,
	output logic hss_activity_o,
	output logic uart_activity_o,
	output cnt_t uart2hss_cnt_o,
	output cnt_t hss2uart_cnt_o
);
	localparam chan_t UART_CHAN = '0;

	logic any_xfer;
	logic uart2hss_xfer;
	logic hss2uart_xfer;

	// Channel 0 joined straight through
	assign hss_tx_data_o[UART_CHAN] = uart_pkt_i;
	assign hss_tx_vld_o[UART_CHAN]  = uart_vld_i;
	assign uart_rdy_o               = hss_tx_rdy_i[UART_CHAN];
	assign out_pkt_o                = hss_rx_data_i[UART_CHAN];
	assign out_vld_o                = hss_rx_vld_i[UART_CHAN];
	assign hss_rx_rdy_o[UART_CHAN]  = out_rdy_i;

	for (genvar i = 1; i < `NUM_CHANS; i++)
	begin : g_idle_chan
		assign hss_tx_data_o[i] = '0;
		assign hss_tx_vld_o[i]  = 1'b0;   // Never sends
		assign hss_rx_rdy_o[i]  = 1'b1;   // Accept and discard
	end

	assign uart2hss_xfer = uart_vld_i && hss_tx_rdy_i[UART_CHAN];
	assign hss2uart_xfer = hss_rx_vld_i[UART_CHAN] && out_rdy_i;

	// Any handshake on any channel, either direction
	always_comb
	begin
		any_xfer = 1'b0;
		for (int i = 0; i < `NUM_CHANS; i++)
			any_xfer |= (hss_tx_vld_o[i] & hss_tx_rdy_i[i]) | (hss_rx_vld_i[i] & hss_rx_rdy_o[i]);
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			hss_activity_o  <= 1'b0;
			uart_activity_o <= 1'b0;
			uart2hss_cnt_o  <= '0;
			hss2uart_cnt_o  <= '0;
		end
		else
		begin
			hss_activity_o  <= any_xfer;
			uart_activity_o <= uart2hss_xfer || hss2uart_xfer;
			if (uart2hss_xfer)
				uart2hss_cnt_o <= uart2hss_cnt_o + 1'b1;
			if (hss2uart_xfer)
				hss2uart_cnt_o <= hss2uart_cnt_o + 1'b1;
		end
	end

endmodule

//--- hw/uart/uart_tx.sv
// UART transmitter for the host link
// Takes one packet and sends it as PKT_BYTES 8N1 bytes, lowest byte first,
// bytes back to back. Ready is only offered while the line is idle.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module uart_tx
	import ftdi_bridge_pkg::*;
(
	input  logic clk_i,
	input  logic rst_i,
	input  pkt_t pkt_data_i,
	input  logic pkt_vld_i,
	output logic pkt_rdy_o,
	output logic tx_o        // Serial line to the FTDI chip
);
	localparam int BAUD_W = $clog2(`BAUD_PERIOD);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_PERIOD - 1);
	localparam int BYTE_W = $clog2(`PKT_BYTES);
	localparam logic [BYTE_W-1:0] BYTE_LAST = BYTE_W'(`PKT_BYTES - 1);
	localparam logic [3:0] LAST_DATA = 4'd8;  // Index of data bit 7
	localparam logic [3:0] STOP_IDX  = 4'd9;

	logic              busy;
	logic [BAUD_W-1:0] baud_cnt;
	logic [3:0]        bit_idx;   // 0 start, 1 to 8 data, 9 stop
	logic [BYTE_W-1:0] byte_cnt;
	pkt_t              pkt_sr;    // Current byte in the low eight bits
	logic              accept;
	logic              bit_end;
	logic              byte_end;

	assign pkt_rdy_o = !busy;
	assign accept    = pkt_vld_i && pkt_rdy_o;
	assign bit_end   = busy && (baud_cnt == BAUD_LAST);
	assign byte_end  = bit_end && (bit_idx == STOP_IDX);

	always_ff @(posedge clk_i)
	begin
		if (accept)
			pkt_sr <= pkt_data_i;
		else if (byte_end)
			pkt_sr <= pkt_sr >> 8;  // Next byte down
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_idx  <= '0;
			byte_cnt <= '0;
			tx_o     <= 1'b1;
		end
		else if (accept)
		begin
			busy     <= 1'b1;
			baud_cnt <= '0;
			bit_idx  <= '0;
			byte_cnt <= '0;
			tx_o     <= 1'b0;  // Start bit on the next cycle
		end
		else if (busy)
		begin
			if (!bit_end)
				baud_cnt <= baud_cnt + 1'b1;
			else if (byte_end)
			begin
				baud_cnt <= '0;
				bit_idx  <= '0;
				if (byte_cnt == BYTE_LAST)
					busy <= 1'b0;  // Line stays high
				else
				begin
					byte_cnt <= byte_cnt + 1'b1;
					tx_o     <= 1'b0;
				end
			end
			else
			begin
				baud_cnt <= '0;
				bit_idx  <= bit_idx + 1'b1;
				tx_o     <= (bit_idx == LAST_DATA) ? 1'b1 : pkt_sr[bit_idx[2:0]];
			end
		end
	end

endmodule

//--- hw/uart/uart_rx.sv
// UART receiver for the host link
// Samples 8N1 bytes at mid-bit and gathers PKT_BYTES of them, lowest byte
// first, into one packet. The packet is held until the router takes it, and a
// packet finishing while another is still held is counted as dropped.

`timescale 1ns/1ps

`include "ftdi_bridge_consts.svh"

module uart_rx
	import ftdi_bridge_pkg::*;
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic rx_i,        // Serial line from the FTDI chip
	output pkt_t pkt_data_o,
	output logic pkt_vld_o,
	input  logic pkt_rdy_i,
	output logic cts_o,       // Host may send
	output logic line_ok_o,   // Framing seen as good
	output cnt_t dropped_o
);
	localparam int BAUD_W = $clog2(`BAUD_PERIOD);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_PERIOD - 1);
	localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(`BAUD_PERIOD / 2 - 1);
	localparam int BYTE_W = $clog2(`PKT_BYTES);
	localparam logic [BYTE_W-1:0] BYTE_LAST = BYTE_W'(`PKT_BYTES - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,  // Checking start bit at its middle
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t         state;
	logic              rx_meta;
	logic              rx_sync;
	logic [BAUD_W-1:0] baud_cnt;
	logic [2:0]        bit_cnt;
	logic [BYTE_W-1:0] byte_cnt;
	logic [7:0]        byte_sr;    // Current byte, LSB arrives first
	pkt_t              asm_q;      // Bytes gathered so far
	pkt_t              asm_next;
	logic              bit_tick;
	logic              stop_tick;
	logic              byte_ok;
	logic              pkt_done;
	logic              pkt_take;

	// Two-stage synchroniser, idles high
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
		end
	end

	assign bit_tick  = (state == RX_DATA) && (baud_cnt == BAUD_LAST);
	assign stop_tick = (state == RX_STOP) && (baud_cnt == BAUD_LAST);
	assign byte_ok   = stop_tick && rx_sync;
	assign pkt_done  = byte_ok && (byte_cnt == BYTE_LAST);
	assign pkt_take  = pkt_done && (!pkt_vld_o || pkt_rdy_i);  // Slot free this cycle
	assign asm_next  = {byte_sr, asm_q[`PKT_BITS-1:8]};         // First byte ends lowest
	assign cts_o     = !pkt_vld_o;

	// Bit and packet assembly
	always_ff @(posedge clk_i)
	begin
		if (bit_tick)
			byte_sr <= {rx_sync, byte_sr[7:1]};
		if (byte_ok)
			asm_q <= asm_next;
		if (pkt_take)
			pkt_data_o <= asm_next;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			state     <= RX_IDLE;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			byte_cnt  <= '0;
			pkt_vld_o <= 1'b0;
			line_ok_o <= 1'b0;
			dropped_o <= '0;
		end
		else
		begin
			case (state)
				RX_IDLE:
				begin
					baud_cnt <= '0;
					if (!rx_sync)
						state <= RX_START;  // Falling edge
				end
				RX_START:
				begin
					if (baud_cnt != BAUD_HALF)
						baud_cnt <= baud_cnt + 1'b1;
					else if (rx_sync)
						state <= RX_IDLE;   // Glitch, not a start bit
					else
					begin
						state    <= RX_DATA;
						baud_cnt <= '0;
						bit_cnt  <= '0;
					end
				end
				RX_DATA:
				begin
					baud_cnt <= bit_tick ? '0 : baud_cnt + 1'b1;
					if (bit_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				default:
				begin
					baud_cnt <= stop_tick ? '0 : baud_cnt + 1'b1;
					if (stop_tick)
						state <= RX_IDLE;
				end
			endcase

			// Byte bookkeeping at mid stop bit
			if (byte_ok)
			begin
				line_ok_o <= 1'b1;
				byte_cnt  <= pkt_done ? '0 : byte_cnt + 1'b1;
			end
			else if (stop_tick)
			begin
				line_ok_o <= 1'b0;  // Framing error, partial packet lost
				byte_cnt  <= '0;
			end

			if (pkt_take)
				pkt_vld_o <= 1'b1;
			else if (pkt_rdy_i)
				pkt_vld_o <= 1'b0;

			if (pkt_done && !pkt_take)
				dropped_o <= dropped_o + 1'b1;
		end
	end

endmodule

//--- common/ftdi_bridge_pkg.sv
// Types shared across the FTDI bridge
// Modules pull these in with a wildcard import in their header.
// Sizes come from the constants header.

`include "ftdi_bridge_consts.svh"

package ftdi_bridge_pkg;

	////////////////////////////////////////////////////////////
	// Packet path
	////////////////////////////////////////////////////////////

	// One packet as carried by the multiplexer
	typedef logic [`PKT_BITS-1:0] pkt_t;

	// Channel number on the multiplexer
	typedef logic [$clog2(`NUM_CHANS)-1:0] chan_t;

	// Packet and drop counters
	typedef logic [`CNT_BITS-1:0] cnt_t;

	////////////////////////////////////////////////////////////
	// Debug bus
	////////////////////////////////////////////////////////////

	typedef logic [7:0]  apb_addr_t;  // Byte offset into the bank
	typedef logic [31:0] apb_data_t;  // Read data word

endpackage

//--- common/ftdi_bridge_consts.svh
// Shared constants for the FTDI to SpiNNaker bridge
// Include wherever packet sizes, UART timing, LED timing or register offsets
// are needed. Guarded against repeated inclusion.

`ifndef FTDI_BRIDGE_CONSTS_SVH
`define FTDI_BRIDGE_CONSTS_SVH

// Packet format
`define PKT_BITS         72          // One SpiNNaker packet
`define PKT_BYTES        9           // UART bytes per packet
`define NUM_CHANS        8           // Multiplexer packet channels

// Timing
`define BAUD_PERIOD      16          // Clock cycles per UART bit
`define BLINK_BIT        5           // Period counter bit for the blink
`define ACTIVITY_TIMEOUT 2048        // Cycles an event stays recent
`define CNT_BITS         32          // Packet counter width

// Debug register offsets
`define REG_VERSION      8'h00
`define REG_STATUS       8'h04
`define REG_UART2HSS     8'h08
`define REG_HSS2UART     8'h0C
`define REG_DROPPED      8'h10

`define BRIDGE_VERSION   32'h0001_0000

`endif
